//--- dv/bmu_dbus_sva.sv
/*
 * Concurrent assertions on the data-bus top level, bound to bmu_dbus_if.
 * Covers one-hot target requests, quiet reset, grant origin and debug
 * info encoding.
 */

`default_nettype none

module bmu_dbus_sva (
  input wire logic                bmu_clk,
  input wire logic                cpurst_b,
  input wire logic                dahbl_req,
  input wire logic                iahbl_req,
  input wire logic                tcip_req,
  input wire logic                sahbl_req,
  input wire logic                lsu_grant,
  input wire bmu_pkg::bmu_state_t dbus_dbginfo
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [3:0] reqs;

  // failed assertions so far, polled by the testbench
  int unsigned fail_cnt = 0;

  assign reqs = {sahbl_req, tcip_req, iahbl_req, dahbl_req};

  a_one_req: assert property (@(posedge bmu_clk) $onehot0(reqs))
    else begin
      $error("more than one target request");
      fail_cnt++;
    end

  a_rst_quiet: assert property (@(posedge bmu_clk) !cpurst_b |-> reqs == 4'b0)
    else begin
      $error("target request during reset");
      fail_cnt++;
    end

  a_grant_src: assert property (@(posedge bmu_clk) disable iff (!cpurst_b)
    lsu_grant |-> |reqs)
    else begin
      $error("lsu_grant without target request");
      fail_cnt++;
    end

  a_dbg_enc: assert property (@(posedge bmu_clk) dbus_dbginfo != 2'b10)
    else begin
      $error("illegal debug state encoding");
      fail_cnt++;
    end

endmodule

bind bmu_dbus_if bmu_dbus_sva u_sva (.*);

`default_nettype wire

//--- dv/bmu_dbus_tb.sv
/*
 * Testbench for the data-bus interface of the bus matrix unit.
 * Random requests from an LCG drive the requester side, four responder
 * processes answer per target, and a reference model of decode and FSM
 * checks target requests, merged responses and debug info every cycle.
 */

`default_nettype none

module bmu_dbus_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int DATA_W  = bmu_pkg::DATA_W_DEF;
  localparam int NUM_TXN = 300;
  localparam int T_CLK   = 20;

  logic bmu_clk, cpurst_b, lsu_req, lsu_write, rtu_async_flush;
  logic [bmu_pkg::ADDR_W-1:0] lsu_addr;
  bmu_pkg::size_t lsu_size;
  bmu_pkg::prot_t lsu_prot;
  logic [DATA_W-1:0] lsu_wdata;
  wire logic lsu_grant, lsu_trans_cmplt, lsu_acc_err;
  wire logic [DATA_W-1:0] lsu_rdata;
  bmu_pkg::region_t dahbl_base, dahbl_mask, iahbl_base, iahbl_mask;
  logic [bmu_pkg::TCIP_W-1:0] tcip_base;
  wire bmu_pkg::bmu_state_t dbus_dbginfo;

  // per target, indexed by the SEL_* constants
  wire bmu_pkg::bus_sel_t req_v;
  wire bmu_pkg::bus_sel_t grnt;
  logic [3:0] grant_ok, cmplt, err, busy, accepted;
  logic [DATA_W-1:0] rd [4];
  int wait_cnt [4];
  wire logic [bmu_pkg::ADDR_W-1:0] dahbl_addr, iahbl_addr, sahbl_addr, tcip_addr;
  wire logic [DATA_W-1:0] dahbl_wdata, iahbl_wdata, sahbl_wdata, tcip_wdata;
  wire logic dahbl_write, iahbl_write, sahbl_write, tcip_write, tcip_supv_mode;
  wire bmu_pkg::size_t dahbl_size, iahbl_size, sahbl_size, tcip_size;
  wire bmu_pkg::prot_t dahbl_prot, iahbl_prot, sahbl_prot;

  logic [31:0] seed = 32'd23472;
  int txn_cnt;
  logic grant_seen;
  bmu_pkg::bmu_state_t m_state, m_next;
  bmu_pkg::bus_sel_t m_sel_f, m_sel_next;

  assign grnt = grant_ok & req_v;

  bmu_dbus_if #(.DATA_W(DATA_W)) UUT (
    .dahbl_req(req_v[0]), .dahbl_grnt(grnt[0]), .dahbl_trans_cmplt(cmplt[0]),
    .dahbl_acc_err(err[0]), .dahbl_rdata(rd[0]),
    .iahbl_req(req_v[1]), .iahbl_grnt(grnt[1]), .iahbl_trans_cmplt(cmplt[1]),
    .iahbl_acc_err(err[1]), .iahbl_rdata(rd[1]),
    .tcip_req(req_v[2]), .tcip_grnt(grnt[2]), .tcip_trans_cmplt(cmplt[2]),
    .tcip_acc_err(err[2]), .tcip_rdata(rd[2]),
    .sahbl_req(req_v[3]), .sahbl_grnt(grnt[3]), .sahbl_trans_cmplt(cmplt[3]),
    .sahbl_acc_err(err[3]), .sahbl_rdata(rd[3]),
    .*
  );

  always #(T_CLK/2) bmu_clk = ~bmu_clk;

  function automatic logic [15:0] lcg_next();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed[30:15];
  endfunction

  // ==========================================================================
  // compare tasks
  // ==========================================================================
  task automatic fail_now(input string name, input logic [DATA_W-1:0] got,
                          input logic [DATA_W-1:0] exp);
    $display("ERROR: %s got %h expected %h at %0t", name, got, exp, $time);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic check_sel(input bmu_pkg::bus_sel_t got, input bmu_pkg::bus_sel_t exp,
                           input string name);
    if (got !== exp) fail_now(name, DATA_W'(got), DATA_W'(exp));
  endtask

  task automatic check_state(input bmu_pkg::bmu_state_t got,
                             input bmu_pkg::bmu_state_t exp, input string name);
    if (got !== exp) fail_now(name, DATA_W'(got), DATA_W'(exp));
  endtask

  task automatic check_data(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                            input string name);
    if (got !== exp) fail_now(name, got, exp);
  endtask

  task automatic check_bit(input logic got, input logic exp, input string name);
    if (got !== exp) fail_now(name, DATA_W'(got), DATA_W'(exp));
  endtask

  // prioritized decode written from the window rules
  function automatic bmu_pkg::bus_sel_t ref_decode(input logic [31:0] a);
    bmu_pkg::bus_sel_t s;
    s = '0;
    if (a[31:28] == tcip_base) s[bmu_pkg::SEL_TCIP] = 1'b1;
    else if ((a[31:20] & dahbl_mask) == dahbl_base) s[bmu_pkg::SEL_DAHBL] = 1'b1;
    else if ((a[31:20] & iahbl_mask) == iahbl_base) s[bmu_pkg::SEL_IAHBL] = 1'b1;
    else s[bmu_pkg::SEL_SAHBL] = 1'b1;
    return s;
  endfunction

  // new request, half the time in the same 1 MB region as before
  task automatic pick_request();
    logic [11:0] tops [6];
    logic [15:0] r;
    tops = '{12'h2A1, 12'h230, 12'h330, 12'hE30, 12'hE71, 12'h5F0};
    if (lcg_next() % 2 == 0) lsu_addr[31:20] = tops[lcg_next() % 6];
    r = lcg_next();
    lsu_addr[19:0] = {r[3:0], lcg_next()};
    r = lcg_next();
    lsu_write = r[0];
    lsu_size  = r[2:1];
    lsu_prot  = r[6:3];
    lsu_wdata = {lcg_next(), lcg_next()};
  endtask

  // ==========================================================================
  // reference model and per-cycle checks, sampled mid-cycle
  // ==========================================================================
  always @(negedge bmu_clk) begin
    bmu_pkg::bus_sel_t dec, exp_req;
    logic en, m_grant, any_cmplt, any_err;
    logic [DATA_W-1:0] exp_rdata;
    if (UUT.u_sva.fail_cnt != 0) begin
      $display("a bound assertion in bmu_dbus_sva failed at %0t", $time);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
    dec = ref_decode(lsu_addr);
    en = (m_state == bmu_pkg::REQ) || (m_state == bmu_pkg::WFG) ||
         ((m_state == bmu_pkg::WFD) && (dec == m_sel_f));
    exp_req = dec & m_sel_f & {4{lsu_req & en}};
    m_grant = |(dec & grnt);
    any_cmplt = |cmplt;
    any_err = |err;
    exp_rdata = '0;
    for (int t = 0; t < 4; t++) if (m_sel_f[t]) exp_rdata |= rd[t];
    check_state(dbus_dbginfo, m_state, "dbus_dbginfo");
    check_sel(req_v, exp_req, "x_req");
    check_bit(lsu_grant, m_grant & en, "lsu_grant");
    check_bit(lsu_trans_cmplt, any_cmplt, "lsu_trans_cmplt");
    if (any_cmplt) begin
      check_bit(lsu_acc_err, any_err, "lsu_acc_err");
      check_data(lsu_rdata, exp_rdata, "lsu_rdata");
    end
    check_data(dahbl_addr, lsu_addr, "dahbl_addr");
    check_data(iahbl_addr, lsu_addr, "iahbl_addr");
    check_data(sahbl_addr, lsu_addr, "sahbl_addr");
    check_data(sahbl_wdata, lsu_wdata, "sahbl_wdata");
    check_data(dahbl_wdata, lsu_wdata, "dahbl_wdata");
    check_data(iahbl_wdata, lsu_wdata, "iahbl_wdata");
    check_data(DATA_W'({dahbl_write, dahbl_size, dahbl_prot}),
               DATA_W'({lsu_write, lsu_size, lsu_prot}), "dahbl_ctrl");
    check_data(DATA_W'({iahbl_write, iahbl_size, iahbl_prot}),
               DATA_W'({lsu_write, lsu_size, lsu_prot}), "iahbl_ctrl");
    check_data(DATA_W'({sahbl_write, sahbl_size, sahbl_prot}),
               DATA_W'({lsu_write, lsu_size, lsu_prot}), "sahbl_ctrl");
    check_data(tcip_addr, {lsu_addr[31:16], dec[bmu_pkg::SEL_TCIP] ? lsu_addr[15:0] : 16'h0},
               "tcip_addr");
    check_data(tcip_wdata, lsu_wdata, "tcip_wdata");
    check_bit(tcip_write, lsu_write, "tcip_write");
    check_bit(tcip_supv_mode, lsu_prot[bmu_pkg::PROT_SUPV], "tcip_supv_mode");
    check_data(DATA_W'(tcip_size), DATA_W'(lsu_size), "tcip_size");

    m_next = m_state;
    case (m_state)
      bmu_pkg::REQ: if (lsu_req) m_next = m_grant ? bmu_pkg::WFD : bmu_pkg::WFG;
      bmu_pkg::WFG: if (m_grant) m_next = bmu_pkg::WFD;
      default: begin
        if (any_cmplt) begin
          if (lsu_req && dec == m_sel_f && !any_err)
            m_next = m_grant ? bmu_pkg::WFD : bmu_pkg::WFG;
          else
            m_next = bmu_pkg::REQ;
        end
      end
    endcase
    if (rtu_async_flush) m_next = bmu_pkg::REQ;
    m_sel_next = (lsu_req && m_state == bmu_pkg::REQ) ? dec : m_sel_f;
    accepted = grnt;
    grant_seen = lsu_grant;
  end

  always @(posedge bmu_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      m_state <= bmu_pkg::REQ;
      m_sel_f <= '0;
    end else begin
      m_state <= m_next;
      m_sel_f <= m_sel_next;
    end
  end

  // ==========================================================================
  // stimulus, requester and target responders
  // ==========================================================================
  always @(posedge bmu_clk) begin
    #2;
    if (cpurst_b) begin
      for (int t = 0; t < 4; t++) begin
        cmplt[t] = 1'b0;
        err[t] = 1'b0;
        if (accepted[t]) begin
          busy[t] = 1'b1;
          wait_cnt[t] = lcg_next() % 4;
        end
        if (busy[t]) begin
          if (wait_cnt[t] == 0) begin
            cmplt[t] = 1'b1;
            err[t] = (lcg_next() % 8 == 0);
            rd[t] = {lcg_next(), lcg_next()};
            busy[t] = 1'b0;
          end else begin
            wait_cnt[t]--;
          end
        end
        grant_ok[t] = !busy[t] && (lcg_next() % 3 != 0);
      end
      if (grant_seen) begin
        txn_cnt++;
        pick_request();
        lsu_req = (lcg_next() % 6 != 0);
      end else if (!lsu_req && lcg_next() % 2 == 0) begin
        pick_request();
        lsu_req = 1'b1;
      end
      rtu_async_flush = (busy == 4'b0) && (lcg_next() % 32 == 0);
    end
  end

  initial begin
    bmu_clk = 1'b0;
    cpurst_b = 1'b0;
    lsu_req = 1'b0;
    lsu_addr = '0;
    lsu_write = 1'b0;
    lsu_size = '0;
    lsu_prot = '0;
    lsu_wdata = '0;
    rtu_async_flush = 1'b0;
    // overlapping windows: dahbl 0x2xx, iahbl xx3x, tcip 0xE
    dahbl_base = 12'h200;
    dahbl_mask = 12'hF00;
    iahbl_base = 12'h030;
    iahbl_mask = 12'h0F0;
    tcip_base = 4'hE;
    grant_ok = '0;
    cmplt = '0;
    err = '0;
    busy = '0;
    accepted = '0;
    grant_seen = 1'b0;
    txn_cnt = 0;
    for (int t = 0; t < 4; t++) begin
      rd[t] = '0;
      wait_cnt[t] = 0;
    end
    repeat (8) @(posedge bmu_clk);
    #1;
    cpurst_b = 1'b1;
    wait (txn_cnt >= NUM_TXN);
    @(posedge bmu_clk);
    #1;
    if (UUT.u_sva.fail_cnt == 0) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      $display("a bound assertion in bmu_dbus_sva failed at %0t", $time);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  end

  // watchdog
  initial begin
    #((8 + NUM_TXN * 10) * T_CLK);
    $display("timeout: only %0d of %0d transfers completed", txn_cnt, NUM_TXN);
    $display("SIMULATION FAILED");
    $fatal(1);
  end

endmodule

`default_nettype wire

//--- files.f
source/bmu_pkg.sv
source/bmu_addr_decode.sv
source/bmu_dbus_fsm.sv
source/bmu_dbus_route.sv
source/bmu_dbus_if.sv
dv/bmu_dbus_sva.sv
dv/bmu_dbus_tb.sv

//--- source/bmu_addr_decode.sv
/*
 * Prioritized address decode for the data bus.
 * tcip wins on its top address bits, then the dahbl and iahbl windows
 * under base and mask, and sahbl takes whatever is left.
 * Output is a one-hot target selection, purely combinational.
 */

`default_nettype none

module bmu_addr_decode (
  input  wire logic [bmu_pkg::ADDR_W-1:0] addr,
  input  wire bmu_pkg::region_t           dahbl_base,
  input  wire bmu_pkg::region_t           dahbl_mask,
  input  wire bmu_pkg::region_t           iahbl_base,
  input  wire bmu_pkg::region_t           iahbl_mask,
  input  wire logic [bmu_pkg::TCIP_W-1:0] tcip_base,
  output bmu_pkg::bus_sel_t               bus_sel
);

  bmu_pkg::region_t             region;
  logic [bmu_pkg::TCIP_W-1:0]   tcip_field;
  logic                         tcip_hit;
  logic                         dahbl_hit;
  logic                         iahbl_hit;
  logic                         sahbl_hit;

  assign region     = addr[bmu_pkg::ADDR_W-1 -: bmu_pkg::REGION_W];
  assign tcip_field = addr[bmu_pkg::ADDR_W-1 -: bmu_pkg::TCIP_W];

  // highest priority
  assign tcip_hit  = (tcip_field == tcip_base);

  assign dahbl_hit = ((region & dahbl_mask) == dahbl_base) & ~tcip_hit;
  assign iahbl_hit = ((region & iahbl_mask) == iahbl_base) & ~tcip_hit & ~dahbl_hit;

  // default target
  assign sahbl_hit = ~tcip_hit & ~dahbl_hit & ~iahbl_hit;

  always_comb begin
    bus_sel                     = '0;
    bus_sel[bmu_pkg::SEL_DAHBL] = dahbl_hit;
    bus_sel[bmu_pkg::SEL_IAHBL] = iahbl_hit;
    bus_sel[bmu_pkg::SEL_TCIP]  = tcip_hit;
    bus_sel[bmu_pkg::SEL_SAHBL] = sahbl_hit;
  end

endmodule

`default_nettype wire

//--- source/bmu_dbus_fsm.sv
/*
 * Request FSM of the data bus.
 * Tracks one outstanding transfer (REQ, WFG, WFD), remembers the target of
 * the last accepted request and enables new address phases only while
 * they go to that same target. A flush returns it to REQ.
 */

`default_nettype none

module bmu_dbus_fsm (
  input  wire logic              bmu_clk,
  input  wire logic              cpurst_b,
  input  wire logic              flush,
  input  wire logic              req,
  input  wire bmu_pkg::bus_sel_t bus_sel,
  input  wire logic              dbus_grant,
  input  wire logic              dbus_cmplt,
  input  wire logic              dbus_acc_err,
  output bmu_pkg::bus_sel_t      bus_sel_f,
  output logic                   req_en,
  output bmu_pkg::bmu_state_t    dbg_state
);

  bmu_pkg::bmu_state_t cur_state;
  bmu_pkg::bmu_state_t next_state;
  logic                bus_sel_same;
  logic                new_req_en;

  // ==========================================================================
  // state register
  // ==========================================================================
  always_ff @(posedge bmu_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      cur_state <= bmu_pkg::REQ;
    end else if (flush) begin
      cur_state <= bmu_pkg::REQ;
    end else begin
      cur_state <= next_state;
    end
  end

  always_comb begin
    next_state = cur_state;
    case (cur_state)
      bmu_pkg::REQ: begin
        if (req) begin
          next_state = dbus_grant ? bmu_pkg::WFD : bmu_pkg::WFG;
        end
      end
      bmu_pkg::WFG: begin
        if (dbus_grant) begin
          next_state = bmu_pkg::WFD;
        end
      end
      bmu_pkg::WFD: begin
        if (dbus_cmplt) begin
          // pipelined follow-on to the same target
          if (req && bus_sel_same && !dbus_acc_err) begin
            next_state = dbus_grant ? bmu_pkg::WFD : bmu_pkg::WFG;
          end else begin
            next_state = bmu_pkg::REQ;
          end
        end
      end
      default: begin
        next_state = bmu_pkg::REQ;
      end
    endcase
  end

  // ==========================================================================
  // remembered target
  // ==========================================================================
  assign new_req_en = (cur_state == bmu_pkg::REQ);

  always_ff @(posedge bmu_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      bus_sel_f <= '0;
    end else if (req && new_req_en) begin
      bus_sel_f <= bus_sel;
    end
  end

  assign bus_sel_same = (bus_sel_f == bus_sel);

  // overlap only allowed while the data phase targets the same port
  assign req_en = (cur_state == bmu_pkg::REQ) |
                  (cur_state == bmu_pkg::WFG) |
                  ((cur_state == bmu_pkg::WFD) & bus_sel_same);

  assign dbg_state = cur_state;

endmodule

`default_nettype wire

//--- source/bmu_dbus_if.sv
/*
 * Data-bus interface of the bus matrix unit, top level.
 * Steers one load/store request stream to tcip, dahbl, iahbl or sahbl
 * by address and merges the responses. Instances and wiring only.
 */

`default_nettype none

module bmu_dbus_if #(
  parameter int DATA_W = bmu_pkg::DATA_W_DEF
) (
  input  wire logic                       bmu_clk,
  input  wire logic                       cpurst_b,
  // requester
  input  wire logic                       lsu_req,
  input  wire logic [bmu_pkg::ADDR_W-1:0] lsu_addr,
  input  wire logic                       lsu_write,
  input  wire bmu_pkg::size_t             lsu_size,
  input  wire bmu_pkg::prot_t             lsu_prot,
  input  wire logic [DATA_W-1:0]          lsu_wdata,
  output logic                            lsu_grant,
  output logic                            lsu_trans_cmplt,
  output logic                            lsu_acc_err,
  output logic [DATA_W-1:0]               lsu_rdata,
  // dahbl
  output logic                            dahbl_req,
  output logic [bmu_pkg::ADDR_W-1:0]      dahbl_addr,
  output logic                            dahbl_write,
  output bmu_pkg::size_t                  dahbl_size,
  output bmu_pkg::prot_t                  dahbl_prot,
  output logic [DATA_W-1:0]               dahbl_wdata,
  input  wire logic                       dahbl_grnt,
  input  wire logic                       dahbl_trans_cmplt,
  input  wire logic                       dahbl_acc_err,
  input  wire logic [DATA_W-1:0]          dahbl_rdata,
  // iahbl
  output logic                            iahbl_req,
  output logic [bmu_pkg::ADDR_W-1:0]      iahbl_addr,
  output logic                            iahbl_write,
  output bmu_pkg::size_t                  iahbl_size,
  output bmu_pkg::prot_t                  iahbl_prot,
  output logic [DATA_W-1:0]               iahbl_wdata,
  input  wire logic                       iahbl_grnt,
  input  wire logic                       iahbl_trans_cmplt,
  input  wire logic                       iahbl_acc_err,
  input  wire logic [DATA_W-1:0]          iahbl_rdata,
  // sahbl
  output logic                            sahbl_req,
  output logic [bmu_pkg::ADDR_W-1:0]      sahbl_addr,
  output logic                            sahbl_write,
  output bmu_pkg::size_t                  sahbl_size,
  output bmu_pkg::prot_t                  sahbl_prot,
  output logic [DATA_W-1:0]               sahbl_wdata,
  input  wire logic                       sahbl_grnt,
  input  wire logic                       sahbl_trans_cmplt,
  input  wire logic                       sahbl_acc_err,
  input  wire logic [DATA_W-1:0]          sahbl_rdata,
  // tcip
  output logic                            tcip_req,
  output logic [bmu_pkg::ADDR_W-1:0]      tcip_addr,
  output logic                            tcip_write,
  output bmu_pkg::size_t                  tcip_size,
  output logic                            tcip_supv_mode,
  output logic [DATA_W-1:0]               tcip_wdata,
  input  wire logic                       tcip_grnt,
  input  wire logic                       tcip_trans_cmplt,
  input  wire logic                       tcip_acc_err,
  input  wire logic [DATA_W-1:0]          tcip_rdata,
  // configuration and control
  input  wire bmu_pkg::region_t           dahbl_base,
  input  wire bmu_pkg::region_t           dahbl_mask,
  input  wire bmu_pkg::region_t           iahbl_base,
  input  wire bmu_pkg::region_t           iahbl_mask,
  input  wire logic [bmu_pkg::TCIP_W-1:0] tcip_base,
  input  wire logic                       rtu_async_flush,
  output bmu_pkg::bmu_state_t             dbus_dbginfo
);

  wire bmu_pkg::bus_sel_t bus_sel;
  wire bmu_pkg::bus_sel_t bus_sel_f;
  wire logic              req_en;
  wire logic              dbus_grant;
  wire logic              dbus_cmplt;
  wire logic              dbus_acc_err;

  // ==========================================================================
  // decode, FSM, routing
  // ==========================================================================
  bmu_addr_decode u_decode (
    .addr      (lsu_addr),
    .*
  );

  bmu_dbus_fsm u_fsm (
    .flush     (rtu_async_flush),
    .req       (lsu_req),
    .dbg_state (dbus_dbginfo),
    .*
  );

  // port names match the top level one to one
  bmu_dbus_route #(
    .DATA_W (DATA_W)
  ) u_route (
    .*
  );

endmodule

`default_nettype wire

//--- source/bmu_dbus_route.sv
/*
 * Request fan-out and response merge for the data bus.
 * Raises one target request when decode and remembered target agree,
 * copies the request fields to all targets and merges grant, completion,
 * error and read data back to the requester. Combinational only.
 */

`default_nettype none

module bmu_dbus_route #(
  parameter int DATA_W = bmu_pkg::DATA_W_DEF
) (
  // requester
  input  wire logic                       lsu_req,
  input  wire logic [bmu_pkg::ADDR_W-1:0] lsu_addr,
  input  wire logic                       lsu_write,
  input  wire bmu_pkg::size_t             lsu_size,
  input  wire bmu_pkg::prot_t             lsu_prot,
  input  wire logic [DATA_W-1:0]          lsu_wdata,
  output logic                            lsu_grant,
  output logic                            lsu_trans_cmplt,
  output logic                            lsu_acc_err,
  output logic [DATA_W-1:0]               lsu_rdata,
  // selection from decode and FSM
  input  wire bmu_pkg::bus_sel_t          bus_sel,
  input  wire bmu_pkg::bus_sel_t          bus_sel_f,
  input  wire logic                       req_en,
  output logic                            dbus_grant,
  output logic                            dbus_cmplt,
  output logic                            dbus_acc_err,
  // dahbl
  output logic                            dahbl_req,
  output logic [bmu_pkg::ADDR_W-1:0]      dahbl_addr,
  output logic                            dahbl_write,
  output bmu_pkg::size_t                  dahbl_size,
  output bmu_pkg::prot_t                  dahbl_prot,
  output logic [DATA_W-1:0]               dahbl_wdata,
  input  wire logic                       dahbl_grnt,
  input  wire logic                       dahbl_trans_cmplt,
  input  wire logic                       dahbl_acc_err,
  input  wire logic [DATA_W-1:0]          dahbl_rdata,
  // iahbl
  output logic                            iahbl_req,
  output logic [bmu_pkg::ADDR_W-1:0]      iahbl_addr,
  output logic                            iahbl_write,
  output bmu_pkg::size_t                  iahbl_size,
  output bmu_pkg::prot_t                  iahbl_prot,
  output logic [DATA_W-1:0]               iahbl_wdata,
  input  wire logic                       iahbl_grnt,
  input  wire logic                       iahbl_trans_cmplt,
  input  wire logic                       iahbl_acc_err,
  input  wire logic [DATA_W-1:0]          iahbl_rdata,
  // sahbl
  output logic                            sahbl_req,
  output logic [bmu_pkg::ADDR_W-1:0]      sahbl_addr,
  output logic                            sahbl_write,
  output bmu_pkg::size_t                  sahbl_size,
  output bmu_pkg::prot_t                  sahbl_prot,
  output logic [DATA_W-1:0]               sahbl_wdata,
  input  wire logic                       sahbl_grnt,
  input  wire logic                       sahbl_trans_cmplt,
  input  wire logic                       sahbl_acc_err,
  input  wire logic [DATA_W-1:0]          sahbl_rdata,
  // tcip
  output logic                            tcip_req,
  output logic [bmu_pkg::ADDR_W-1:0]      tcip_addr,
  output logic                            tcip_write,
  output bmu_pkg::size_t                  tcip_size,
  output logic                            tcip_supv_mode,
  output logic [DATA_W-1:0]               tcip_wdata,
  input  wire logic                       tcip_grnt,
  input  wire logic                       tcip_trans_cmplt,
  input  wire logic                       tcip_acc_err,
  input  wire logic [DATA_W-1:0]          tcip_rdata
);

  bmu_pkg::bus_sel_t                req_vec;
  bmu_pkg::bus_sel_t                grnt_vec;
  logic [bmu_pkg::TCIP_LOW_W-1:0]   tcip_addr_low;

  // ==========================================================================
  // request fan-out
  // ==========================================================================
  // decode and remembered target must agree
  assign req_vec = bus_sel & bus_sel_f & {4{lsu_req & req_en}};

  assign dahbl_req = req_vec[bmu_pkg::SEL_DAHBL];
  assign iahbl_req = req_vec[bmu_pkg::SEL_IAHBL];
  assign tcip_req  = req_vec[bmu_pkg::SEL_TCIP];
  assign sahbl_req = req_vec[bmu_pkg::SEL_SAHBL];

  assign dahbl_addr  = lsu_addr;
  assign dahbl_write = lsu_write;
  assign dahbl_size  = lsu_size;
  assign dahbl_prot  = lsu_prot;
  assign dahbl_wdata = lsu_wdata;

  assign iahbl_addr  = lsu_addr;
  assign iahbl_write = lsu_write;
  assign iahbl_size  = lsu_size;
  assign iahbl_prot  = lsu_prot;
  assign iahbl_wdata = lsu_wdata;

  assign sahbl_addr  = lsu_addr;
  assign sahbl_write = lsu_write;
  assign sahbl_size  = lsu_size;
  assign sahbl_prot  = lsu_prot;
  assign sahbl_wdata = lsu_wdata;

  // low offset only when tcip is the decoded target
  assign tcip_addr_low  = {bmu_pkg::TCIP_LOW_W{bus_sel[bmu_pkg::SEL_TCIP]}} &
                          lsu_addr[bmu_pkg::TCIP_LOW_W-1:0];
  assign tcip_addr      = {lsu_addr[bmu_pkg::ADDR_W-1:bmu_pkg::TCIP_LOW_W], tcip_addr_low};
  assign tcip_write     = lsu_write;
  assign tcip_size      = lsu_size;
  assign tcip_supv_mode = lsu_prot[bmu_pkg::PROT_SUPV];
  assign tcip_wdata     = lsu_wdata;

  // ==========================================================================
  // response merge
  // ==========================================================================
  always_comb begin
    grnt_vec                     = '0;
    grnt_vec[bmu_pkg::SEL_DAHBL] = dahbl_grnt;
    grnt_vec[bmu_pkg::SEL_IAHBL] = iahbl_grnt;
    grnt_vec[bmu_pkg::SEL_TCIP]  = tcip_grnt;
    grnt_vec[bmu_pkg::SEL_SAHBL] = sahbl_grnt;
  end

  assign dbus_grant   = |(bus_sel & grnt_vec);
  assign dbus_cmplt   = dahbl_trans_cmplt | iahbl_trans_cmplt |
                        tcip_trans_cmplt | sahbl_trans_cmplt;
  assign dbus_acc_err = dahbl_acc_err | iahbl_acc_err | tcip_acc_err | sahbl_acc_err;

  assign lsu_grant       = dbus_grant & req_en;
  assign lsu_trans_cmplt = dbus_cmplt;
  assign lsu_acc_err     = dbus_acc_err;

  // data phase belongs to the remembered target
  assign lsu_rdata = ({DATA_W{bus_sel_f[bmu_pkg::SEL_DAHBL]}} & dahbl_rdata) |
                     ({DATA_W{bus_sel_f[bmu_pkg::SEL_IAHBL]}} & iahbl_rdata) |
                     ({DATA_W{bus_sel_f[bmu_pkg::SEL_TCIP]}}  & tcip_rdata)  |
                     ({DATA_W{bus_sel_f[bmu_pkg::SEL_SAHBL]}} & sahbl_rdata);

endmodule

`default_nettype wire

//--- source/bmu_pkg.sv
/*
 * Shared definitions for the data-bus side of the bus matrix unit.
 * Widths, the request FSM encoding (also used as debug info), target
 * selection indices and field types. Referenced by scoped name only.
 */

`default_nettype none

package bmu_pkg;

  // ==========================================================================
  // widths
  // ==========================================================================
  localparam int ADDR_W     = 32;
  localparam int DATA_W_DEF = 32;

  // top address bits compared for the AHB-lite windows
  localparam int REGION_W   = 12;

  // top address bits compared for tcip, low bits forwarded to it
  localparam int TCIP_W     = 4;
  localparam int TCIP_LOW_W = 16;

  // ==========================================================================
  // FSM state, same encoding goes out on dbus_dbginfo
  // ==========================================================================
  typedef enum logic [1:0] {
    REQ = 2'b00,
    WFD = 2'b01,
    WFG = 2'b11
  } bmu_state_t;

  // ==========================================================================
  // target selection
  // ==========================================================================
  // one-hot, one bit per target
  typedef logic [3:0] bus_sel_t;

  localparam int SEL_DAHBL = 0;
  localparam int SEL_IAHBL = 1;
  localparam int SEL_TCIP  = 2;
  localparam int SEL_SAHBL = 3;

  // ==========================================================================
  // request fields
  // ==========================================================================
  typedef logic [1:0] size_t;
  typedef logic [3:0] prot_t;

  // supervisor mode bit of prot
  localparam int PROT_SUPV = 1;

  typedef logic [REGION_W-1:0] region_t;

endpackage

`default_nettype wire
